// ==== include/x86_exec_settings.svh ====
// Reset values and flag bit indices follow the 8086 register file layout used by the datapath.
`ifndef X86_EXEC_SETTINGS_SVH
`define X86_EXEC_SETTINGS_SVH

`define CS_RESET 16'hf000  // Code segment after reset.
`define IP_RESET 16'hfff0  // Instruction pointer after reset.

`define REG_CX 4'd1        // Count register.
`define REG_DX 4'd2        // High half of word MUL.
`define REG_CS 4'd9        // Code segment.
`define REG_IP 4'd15       // Instruction pointer.

`define FLAG_CF 0          // Carry.
`define FLAG_PF 1          // Parity of low byte.
`define FLAG_AF 2          // Auxiliary carry out of bit 3.
`define FLAG_ZF 3          // Zero.
`define FLAG_SF 4          // Sign.
`define FLAG_TF 5          // Trap, passed through.
`define FLAG_IF 6          // Interrupt enable, passed through.
`define FLAG_DF 7          // Direction, passed through.
`define FLAG_OF 8          // Overflow.

`endif

// ==== hw/x86_exec_pkg.sv ====
// Shared types of the execution datapath; enum encodings are fixed for the command stream.
package x86_exec_pkg;

  // One machine word.
  typedef logic [15:0] word_t;

  // Register number, 0..7 general, 8..11 segment, 12..15 spare.
  typedef logic [3:0] reg_addr_t;

  // Flags vector, bit positions as in the settings header.
  typedef logic [8:0] flags_t;

  // ALU operations carried by a command.
  typedef enum logic [3:0] {
    OP_MOV = 4'd0,  // Copy source.
    OP_ADD = 4'd1,
    OP_SUB = 4'd2,
    OP_CMP = 4'd3,  // Subtract, flags only.
    OP_AND = 4'd4,
    OP_OR  = 4'd5,
    OP_XOR = 4'd6,
    OP_INC = 4'd7,  // Keeps CF.
    OP_DEC = 4'd8,  // Keeps CF.
    OP_MUL = 4'd9   // Unsigned, high half to DX.
  } alu_op_t;

  // Result register occupancy.
  typedef enum logic {
    S_IDLE = 1'b0,  // Result register empty.
    S_HOLD = 1'b1   // Result waiting for res_ready.
  } seq_state_t;

endpackage

// ==== hw/regfile_if.sv ====
// Register file link; reads are combinational and writes land on the next clock edge.
`timescale 1ns/1ps

interface regfile_if;
  import x86_exec_pkg::*;

  reg_addr_t addr_a;      // Read port a address.
  reg_addr_t addr_b;      // Read port b address.
  logic      rd_byte;     // Byte read mode for both ports.
  logic      wr;          // Main write strobe.
  reg_addr_t wr_addr;     // Main write address.
  word_t     wr_data;     // Main write data.
  logic      wr_word;     // Word write, else byte rules.
  logic      wrhi;        // Write wr_hi_data to DX.
  word_t     wr_hi_data;
  logic      wrfl;        // Load flags register.
  flags_t    wr_flags;
  word_t     a;           // Port a data.
  word_t     b;           // Port b data.
  flags_t    flags;       // Current flags.
  logic      cx_zero;     // CX is zero, write forwarded.

  modport ctrl (output addr_a, addr_b, rd_byte, wr, wr_addr, wr_data, wr_word,
                output wrhi, wr_hi_data, wrfl, wr_flags,
                input a, b, flags, cx_zero);
  modport rf (input addr_a, addr_b, rd_byte, wr, wr_addr, wr_data, wr_word,
              input wrhi, wr_hi_data, wrfl, wr_flags,
              output a, b, flags, cx_zero);
endinterface

// ==== hw/regfile.sv ====
// Sixteen word registers plus flags; byte writes to 4..7 hit the high byte of 0..3 and wrhi goes to DX.
`timescale 1ns/1ps

`include "x86_exec_settings.svh"

module regfile (
  input logic clk,
  input logic rst,
  regfile_if.rf rf
);
  import x86_exec_pkg::*;

  word_t     r [16];   // Register array.
  flags_t    flags_q;  // Flags register.
  logic [7:0] a8;      // Byte selected on port a.
  logic [7:0] b8;      // Byte selected on port b.
  logic      cx_wr;    // Word write to CX this cycle.

  // Byte view of 0..7 is AL CL DL BL AH CH DH BH.
  assign a8 = rf.addr_a[2] ? r[{2'b00, rf.addr_a[1:0]}][15:8]
                           : r[rf.addr_a][7:0];
  assign b8 = rf.addr_b[2] ? r[{2'b00, rf.addr_b[1:0]}][15:8]
                           : r[rf.addr_b][7:0];

  // Byte reads of general registers come back sign-extended.
  assign rf.a = (rf.rd_byte && !rf.addr_a[3]) ? {{8{a8[7]}}, a8} : r[rf.addr_a];
  assign rf.b = (rf.rd_byte && !rf.addr_b[3]) ? {{8{b8[7]}}, b8} : r[rf.addr_b];

  assign rf.flags = flags_q;

  // CX status sees the value being written in the same cycle.
  assign cx_wr      = rf.wr && rf.wr_word && (rf.wr_addr == `REG_CX);
  assign rf.cx_zero = cx_wr ? (rf.wr_data == 16'd0) : (r[`REG_CX] == 16'd0);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 16; i++) begin
        r[i] <= 16'd0;
      end
      r[`REG_CS] <= `CS_RESET;  // CS comes up at f000.
      r[`REG_IP] <= `IP_RESET;  // IP comes up at fff0.
      flags_q    <= 9'd0;
    end else begin
      if (rf.wr) begin
        if (rf.wr_word) begin
          r[rf.wr_addr] <= rf.wr_data;  // Full word.
        end else if (rf.wr_addr[3:2] == 2'b10) begin
          // Segment registers take the byte as a signed word.
          r[rf.wr_addr] <= {{8{rf.wr_data[7]}}, rf.wr_data[7:0]};
        end else if (rf.wr_addr[3] == rf.wr_addr[2]) begin
          r[rf.wr_addr][7:0] <= rf.wr_data[7:0];  // AL..BL or spare low byte.
        end else begin
          r[{2'b00, rf.wr_addr[1:0]}][15:8] <= rf.wr_data[7:0];  // AH..BH.
        end
      end
      if (rf.wrhi) begin
        r[`REG_DX] <= rf.wr_hi_data;  // MUL high half.
      end
      if (rf.wrfl) begin
        flags_q <= rf.wr_flags;
      end
    end
  end

  // The sequencer must never aim the main write at DX while the high half lands there.
  a_no_dx_clash: assert property (@(posedge clk) disable iff (rst)
    rf.wrhi |-> !(rf.wr && rf.wr_word && rf.wr_addr == `REG_DX))
    else $error("wrhi collides with a word write to DX");

endmodule

// ==== hw/alu.sv ====
// Purely combinational ALU; byte MUL yields a full 16-bit product and assumes AX as destination.
`timescale 1ns/1ps

`include "x86_exec_settings.svh"

module alu (
  input  x86_exec_pkg::alu_op_t op,
  input  x86_exec_pkg::word_t   x,
  input  x86_exec_pkg::word_t   y,
  input  logic                  byte_mode,
  input  x86_exec_pkg::flags_t  flags_in,
  output x86_exec_pkg::word_t   result,
  output x86_exec_pkg::word_t   result_hi,
  output x86_exec_pkg::flags_t  flags_out,
  output logic                  write_dst
);
  import x86_exec_pkg::*;

  word_t       addend;   // Second adder operand before inversion.
  logic        sub;      // Subtract select.
  logic [16:0] sum16;    // Word adder with carry out.
  logic [8:0]  sum8;     // Byte adder with carry out.
  logic [31:0] prod_w;   // Word product.
  logic [15:0] prod_b;   // Byte product.
  word_t       raw;      // Result before byte extension.
  logic        carry;    // Carry or borrow of the active width.
  logic        xs;       // Operand signs at the active width.
  logic        ys;
  logic        rs;
  logic        ovf;      // Signed overflow of add or subtract.
  logic        zf;
  logic        sf;
  logic        pf;

  // Adder setup per operation.
  always_comb begin
    addend = y;
    sub    = 1'b0;
    case (op)
      OP_SUB, OP_CMP: sub = 1'b1;
      OP_INC: addend = 16'd1;
      OP_DEC: begin
        addend = 16'd1;
        sub    = 1'b1;
      end
      default: ;
    endcase
  end

  assign sum16  = {1'b0, x} + {1'b0, addend ^ {16{sub}}} + 17'(sub);
  assign sum8   = {1'b0, x[7:0]} + {1'b0, addend[7:0] ^ {8{sub}}} + 9'(sub);
  assign prod_w = {16'd0, x} * {16'd0, y};
  assign prod_b = {8'd0, x[7:0]} * {8'd0, y[7:0]};

  always_comb begin
    raw       = x;
    result_hi = 16'd0;
    case (op)
      OP_MOV:                                 raw = y;
      OP_ADD, OP_SUB, OP_CMP, OP_INC, OP_DEC: raw = sum16[15:0];
      OP_AND:                                 raw = x & y;
      OP_OR:                                  raw = x | y;
      OP_XOR:                                 raw = x ^ y;
      OP_MUL: begin
        raw       = byte_mode ? prod_b : prod_w[15:0];
        result_hi = byte_mode ? 16'd0 : prod_w[31:16];  // Goes to DX.
      end
      default: ;
    endcase
  end

  // Byte results are sign-extended, except MUL which fills AX.
  assign result = (byte_mode && op != OP_MUL) ? {{8{raw[7]}}, raw[7:0]} : raw;
  assign write_dst = (op != OP_CMP);  // CMP only sets flags.

  assign carry = (byte_mode ? sum8[8] : sum16[16]) ^ sub;  // Borrow on subtract.
  assign xs    = byte_mode ? x[7] : x[15];
  assign ys    = byte_mode ? addend[7] : addend[15];
  assign rs    = byte_mode ? raw[7] : raw[15];
  assign ovf   = (xs ^ ys ^ ~sub) & (xs ^ rs);
  assign zf    = byte_mode ? (result[7:0] == 8'd0) : (result == 16'd0);
  assign sf    = rs;
  assign pf    = ~^result[7:0];  // Even parity of low byte.

  always_comb begin
    flags_out = flags_in;  // TF, IF, DF always pass.
    case (op)
      OP_ADD, OP_SUB, OP_CMP, OP_INC, OP_DEC: begin
        if (op != OP_INC && op != OP_DEC) begin
          flags_out[`FLAG_CF] = carry;
        end
        flags_out[`FLAG_AF] = x[4] ^ addend[4] ^ raw[4];
        flags_out[`FLAG_OF] = ovf;
        flags_out[`FLAG_ZF] = zf;
        flags_out[`FLAG_SF] = sf;
        flags_out[`FLAG_PF] = pf;
      end
      OP_AND, OP_OR, OP_XOR: begin
        flags_out[`FLAG_CF] = 1'b0;
        flags_out[`FLAG_OF] = 1'b0;
        flags_out[`FLAG_AF] = 1'b0;
        flags_out[`FLAG_ZF] = zf;
        flags_out[`FLAG_SF] = sf;
        flags_out[`FLAG_PF] = pf;
      end
      OP_MUL: begin
        // Upper half nonzero means the product did not fit.
        flags_out[`FLAG_CF] = byte_mode ? |prod_b[15:8] : |prod_w[31:16];
        flags_out[`FLAG_OF] = byte_mode ? |prod_b[15:8] : |prod_w[31:16];
      end
      default: ;  // MOV leaves flags alone.
    endcase
  end

endmodule

// ==== hw/exec_seq.sv ====
// One command per cycle with a single result slot; word MUL must not name DX as destination.
`timescale 1ns/1ps

module exec_seq (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      cmd_valid,
  output logic                      cmd_ready,
  input  x86_exec_pkg::alu_op_t     cmd_op,
  input  x86_exec_pkg::reg_addr_t   cmd_dst,
  input  x86_exec_pkg::reg_addr_t   cmd_src,
  input  logic                      cmd_use_imm,
  input  x86_exec_pkg::word_t       cmd_imm,
  input  logic                      cmd_byte,
  output logic                      res_valid,
  input  logic                      res_ready,
  output x86_exec_pkg::word_t       res_value,
  output x86_exec_pkg::word_t       res_hi,
  output x86_exec_pkg::flags_t      res_flags,
  output logic                      res_cx_zero,
  regfile_if.ctrl                   rf,
  output x86_exec_pkg::alu_op_t     alu_op,
  output x86_exec_pkg::word_t       alu_x,
  output x86_exec_pkg::word_t       alu_y,
  output logic                      alu_byte,
  output x86_exec_pkg::flags_t      alu_flags_in,
  input  x86_exec_pkg::word_t       alu_result,
  input  x86_exec_pkg::word_t       alu_result_hi,
  input  x86_exec_pkg::flags_t      alu_flags_out,
  input  logic                      alu_write_dst
);
  import x86_exec_pkg::*;

  seq_state_t state;  // Result slot occupancy.
  logic       fire;   // Command transfer this edge.
  logic       is_mul;

  // Accept when the slot is free or drains on this edge.
  assign cmd_ready = (state == S_IDLE) || res_ready;
  assign fire      = cmd_valid && cmd_ready;
  assign res_valid = (state == S_HOLD);
  assign is_mul    = (cmd_op == OP_MUL);

  // Destination on port a, source on port b.
  assign rf.addr_a  = cmd_dst;
  assign rf.addr_b  = cmd_src;
  assign rf.rd_byte = cmd_byte;

  assign alu_op       = cmd_op;
  assign alu_x        = rf.a;
  assign alu_y        = cmd_use_imm ? cmd_imm : rf.b;
  assign alu_byte     = cmd_byte;
  assign alu_flags_in = rf.flags;

  // Writes happen only on the transfer edge.
  assign rf.wr         = fire && alu_write_dst;
  assign rf.wr_addr    = cmd_dst;
  assign rf.wr_data    = alu_result;
  assign rf.wr_word    = !cmd_byte || is_mul;  // Byte MUL fills AX.
  assign rf.wrhi       = fire && is_mul && !cmd_byte;
  assign rf.wr_hi_data = alu_result_hi;
  assign rf.wrfl       = fire;
  assign rf.wr_flags   = alu_flags_out;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= S_IDLE;
    end else if (fire) begin
      state <= S_HOLD;
    end else if (res_ready) begin
      state <= S_IDLE;  // Slot drained with nothing new.
    end
  end

  // Result payload loads with the register write.
  always_ff @(posedge clk) begin
    if (fire) begin
      res_value   <= alu_result;
      res_hi      <= alu_result_hi;
      res_flags   <= alu_flags_out;
      res_cx_zero <= rf.cx_zero;  // Includes this write to CX.
    end
  end

  // A waiting command keeps its fields until it is taken.
  a_cmd_stable: assert property (@(posedge clk) disable iff (rst)
    (cmd_valid && !cmd_ready) |=> (cmd_valid && $stable(cmd_op) && $stable(cmd_dst)
                                   && $stable(cmd_src) && $stable(cmd_use_imm)
                                   && $stable(cmd_imm) && $stable(cmd_byte)))
    else $error("command changed before it was accepted");

endmodule

// ==== hw/exec_top.sv ====
// Execution datapath top; command fields must hold while cmd_valid is high.
`timescale 1ns/1ps

module exec_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    cmd_valid,
  output logic                    cmd_ready,
  input  x86_exec_pkg::alu_op_t   cmd_op,
  input  x86_exec_pkg::reg_addr_t cmd_dst,
  input  x86_exec_pkg::reg_addr_t cmd_src,
  input  logic                    cmd_use_imm,
  input  x86_exec_pkg::word_t     cmd_imm,
  input  logic                    cmd_byte,
  output logic                    res_valid,
  input  logic                    res_ready,
  output x86_exec_pkg::word_t     res_value,
  output x86_exec_pkg::word_t     res_hi,
  output x86_exec_pkg::flags_t    res_flags,
  output logic                    res_cx_zero
);
  import x86_exec_pkg::*;

  alu_op_t alu_op;        // Sequencer to ALU.
  word_t   alu_x;
  word_t   alu_y;
  logic    alu_byte;
  flags_t  alu_flags_in;
  word_t   alu_result;    // ALU back to sequencer.
  word_t   alu_result_hi;
  flags_t  alu_flags_out;
  logic    alu_write_dst;

  regfile_if rf_link ();

  exec_seq u_seq (
    .clk, .rst,
    .cmd_valid, .cmd_ready, .cmd_op, .cmd_dst, .cmd_src,
    .cmd_use_imm, .cmd_imm, .cmd_byte,
    .res_valid, .res_ready, .res_value, .res_hi, .res_flags, .res_cx_zero,
    .rf (rf_link.ctrl),
    .alu_op, .alu_x, .alu_y, .alu_byte, .alu_flags_in,
    .alu_result, .alu_result_hi, .alu_flags_out, .alu_write_dst
  );

  alu u_alu (
    .op        (alu_op),
    .x         (alu_x),
    .y         (alu_y),
    .byte_mode (alu_byte),
    .flags_in  (alu_flags_in),
    .result    (alu_result),
    .result_hi (alu_result_hi),
    .flags_out (alu_flags_out),
    .write_dst (alu_write_dst)
  );

  regfile u_rf (
    .clk,
    .rst,
    .rf (rf_link.rf)
  );

endmodule

// ==== testbench/exec_tb.sv ====
// Reads testbench/exec_tests.txt relative to the project root; expected values assume the reset state.
`timescale 1ns/1ps

module exec_tb;
  import x86_exec_pkg::*;

  localparam int CLK_PERIOD = 40;  // ns.

  logic      clk;
  logic      rst;
  logic      cmd_valid;
  logic      cmd_ready;
  alu_op_t   cmd_op;
  reg_addr_t cmd_dst;
  reg_addr_t cmd_src;
  logic      cmd_use_imm;
  word_t     cmd_imm;
  logic      cmd_byte;
  logic      res_valid;
  logic      res_ready;
  word_t     res_value;
  word_t     res_hi;
  flags_t    res_flags;
  logic      res_cx_zero;

  string     t_name[$];     // One entry per test line.
  alu_op_t   t_op[$];
  reg_addr_t t_dst[$];
  reg_addr_t t_src[$];
  logic      t_use_imm[$];
  word_t     t_imm[$];
  logic      t_byte[$];
  word_t     t_value[$];    // Expected result fields.
  word_t     t_hi[$];
  flags_t    t_flags[$];
  logic      t_cx_zero[$];

  int          pending[$];  // Accepted commands, oldest first.
  int          n_done;      // Results taken.
  logic [31:0] lfsr;        // Stall pattern source.
  logic        loaded;

  exec_top UUT (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Taps 32, 22, 2, 1.
  function automatic logic random_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic bit decode_op(string s, output alu_op_t op);
    decode_op = 1'b1;
    op        = OP_MOV;
    case (s)
      "MOV": op = OP_MOV;
      "ADD": op = OP_ADD;
      "SUB": op = OP_SUB;
      "CMP": op = OP_CMP;
      "AND": op = OP_AND;
      "OR":  op = OP_OR;
      "XOR": op = OP_XOR;
      "INC": op = OP_INC;
      "DEC": op = OP_DEC;
      "MUL": op = OP_MUL;
      default: decode_op = 1'b0;  // Unknown mnemonic.
    endcase
  endfunction

  task automatic abort_run();
    $display(">>> FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic compare_word(string test, string field, word_t expected, word_t actual);
    if (actual !== expected) begin
      $display("error %s %s expected %h actual %h", test, field, expected, actual);
      abort_run();
    end
  endtask

  task automatic compare_flags(string test, flags_t expected, flags_t actual);
    if (actual !== expected) begin
      $display("error %s flags expected %h actual %h", test, expected, actual);
      abort_run();
    end
  endtask

  task automatic compare_bit(string test, string field, logic expected, logic actual);
    if (actual !== expected) begin
      $display("error %s %s expected %b actual %b", test, field, expected, actual);
      abort_run();
    end
  endtask

  task automatic load_tests();
    int          fd;
    int          n;
    string       name;
    string       op_name;
    string       rest;
    alu_op_t     op;
    logic [31:0] f [9];  // Numeric columns after the mnemonic.
    fd = $fopen("testbench/exec_tests.txt", "r");
    if (fd == 0) begin
      $display("cannot open testbench/exec_tests.txt");
      abort_run();
    end
    while (!$feof(fd)) begin
      n = $fscanf(fd, "%s", name);
      if (n != 1) break;
      if (name[0] == "#") begin
        n = $fgets(rest, fd);  // Skip comment line.
        continue;
      end
      n = $fscanf(fd, "%s %h %h %h %h %h %h %h %h %h", op_name,
                  f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
      if (n != 10 || !decode_op(op_name, op)) begin
        $display("test line %s is malformed", name);
        abort_run();
      end
      t_name.push_back(name);
      t_op.push_back(op);
      t_dst.push_back(f[0][3:0]);
      t_src.push_back(f[1][3:0]);
      t_use_imm.push_back(f[2][0]);
      t_imm.push_back(f[3][15:0]);
      t_byte.push_back(f[4][0]);
      t_value.push_back(f[5][15:0]);
      t_hi.push_back(f[6][15:0]);
      t_flags.push_back(f[7][8:0]);
      t_cx_zero.push_back(f[8][0]);
    end
    $fclose(fd);
    if (t_name.size() == 0) begin
      $display("the test file holds no tests");
      abort_run();
    end
  endtask

  // Called right after a rising edge; returns after the transfer edge.
  task automatic send_command(int i);
    logic took;
    cmd_valid   <= 1'b1;
    cmd_op      <= t_op[i];
    cmd_dst     <= t_dst[i];
    cmd_src     <= t_src[i];
    cmd_use_imm <= t_use_imm[i];
    cmd_imm     <= t_imm[i];
    cmd_byte    <= t_byte[i];
    took = 1'b0;
    while (!took) begin
      @(negedge clk);
      took = cmd_valid && cmd_ready;  // Handshake settled mid-cycle.
      @(posedge clk);
    end
    pending.push_back(i);
  endtask

  task automatic check_result(int i);
    compare_word(t_name[i], "value", t_value[i], res_value);
    compare_word(t_name[i], "hi", t_hi[i], res_hi);
    compare_flags(t_name[i], t_flags[i], res_flags);
    compare_bit(t_name[i], "cx_zero", t_cx_zero[i], res_cx_zero);
  endtask

  initial begin
    lfsr        = 32'h5f07_bf17;
    loaded      = 1'b0;
    n_done      = 0;
    rst         = 1'b1;
    cmd_valid   = 1'b0;
    cmd_op      = OP_MOV;
    cmd_dst     = 4'd0;
    cmd_src     = 4'd0;
    cmd_use_imm = 1'b0;
    cmd_imm     = 16'd0;
    cmd_byte    = 1'b0;
    res_ready   = 1'b0;
    load_tests();
    loaded = 1'b1;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < t_name.size(); i++) begin
      send_command(i);  // Back to back when the slot drains.
    end
    cmd_valid <= 1'b0;
    while (n_done < t_name.size()) @(posedge clk);
    @(negedge clk);
    if (res_valid) begin
      $display("an extra result appeared after the last test");
      abort_run();
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

  // Random back-pressure, about half the cycles.
  initial begin
    forever begin
      @(posedge clk);
      if (rst) begin
        res_ready <= 1'b0;
      end else begin
        res_ready <= random_bit();
      end
    end
  end

  // Every held cycle is checked, so a value that moves during a stall fails too.
  initial begin
    forever begin
      @(negedge clk);
      if (!rst && res_valid) begin
        if (pending.size() == 0) begin
          $display("a result appeared with no command outstanding");
          abort_run();
        end
        check_result(pending[0]);
        if (res_ready) begin
          pending.delete(0);
          n_done++;
        end
      end
    end
  end

  initial begin
    wait (loaded);
    repeat (t_name.size() * 16 + 50) @(posedge clk);
    $display("results stopped arriving before the time limit");
    abort_run();
  end

endmodule

// ==== testbench/exec_tests.txt ====
# name op dst src use_imm imm byte exp_value exp_hi exp_flags exp_cx_zero, numbers in hex
# Registers 0 AX 1 CX 2 DX 3 BX, 8..b segment with 9 CS, c..f spare with f IP; byte 4..7 AH..BH
reset_cs        MOV 0 9 0 0000 0 f000 0000 000 1
reset_ip        MOV 3 f 0 0000 0 fff0 0000 000 1
mov_ax_7fff     MOV 0 0 1 7fff 0 7fff 0000 000 1
add_ovf         ADD 0 0 1 0001 0 8000 0000 116 1
mov_ax_ffff     MOV 0 0 1 ffff 0 ffff 0000 116 1
add_carry       ADD 0 0 1 0001 0 0000 0000 00f 1
mov_ax_1234     MOV 0 0 1 1234 0 1234 0000 00f 1
sub_ax          SUB 0 0 1 0235 0 0fff 0000 006 1
cmp_ax          CMP 0 0 1 1000 0 ffff 0000 013 1
cmp_keeps_ax    MOV 3 0 0 0000 0 0fff 0000 013 1
and_ax          AND 0 0 1 00f0 0 00f0 0000 002 1
or_ax           OR  0 0 1 8000 0 80f0 0000 012 1
xor_ax_self     XOR 0 0 0 0000 0 0000 0000 00a 1
sub_borrow      SUB 0 0 1 0001 0 ffff 0000 017 1
inc_keeps_cf    INC 0 0 0 0000 0 0000 0000 00f 1
dec_ax          DEC 0 0 0 0000 0 ffff 0000 017 1
mov_ax_word     MOV 0 0 1 1234 0 1234 0000 017 1
mov_ah_imm      MOV 4 0 1 0056 1 0056 0000 017 1
ax_both_bytes   MOV 3 0 0 0000 0 5634 0000 017 1
mov_dl_80       MOV 2 0 1 0080 1 ff80 0000 017 1
dl_sign_ext     MOV 3 2 0 0000 1 ff80 0000 017 1
seg_byte_write  MOV 8 0 1 0090 1 ff90 0000 017 1
seg_readback    MOV 0 8 0 0000 0 ff90 0000 017 1
spare_word      MOV c 0 1 abcd 0 abcd 0000 017 1
spare_byte      MOV c 0 1 0012 1 0012 0000 017 1
spare_readback  MOV 0 c 0 0000 0 ab12 0000 017 1
mov_ax_mul      MOV 0 0 1 1234 0 1234 0000 017 1
mul_word        MUL 0 0 1 0100 0 3400 0012 117 1
dx_readback     MOV 3 2 0 0000 0 0012 0000 117 1
mul_word_small  MUL 0 0 1 0002 0 6800 0000 016 1
dx_cleared      MOV 3 2 0 0000 0 0000 0000 016 1
mov_al_c8       MOV 0 0 1 00c8 0 00c8 0000 016 1
mul_byte        MUL 0 0 1 0003 1 0258 0000 117 1
mul_byte_ax     MOV 3 0 0 0000 0 0258 0000 117 1
mov_cx_1        MOV 1 0 1 0001 0 0001 0000 117 0
dec_cx_zero     DEC 1 0 0 0000 0 0000 0000 00b 1
other_reg_cx    MOV 3 0 1 0007 0 0007 0000 00b 1
dec_cx_neg      DEC 1 0 0 0000 0 ffff 0000 017 0
add_bx_cx       ADD 3 1 0 0000 0 0006 0000 007 0
add_al_byte     ADD 0 0 1 00b0 1 0008 0000 001 0

// ==== all.f ====
+incdir+include
hw/x86_exec_pkg.sv
hw/regfile_if.sv
hw/regfile.sv
hw/alu.sv
hw/exec_seq.sv
hw/exec_top.sv
testbench/exec_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the exec_top testbench with Verilator, run it and scan the log.
cd "$(dirname "$0")" || exit 1
log=sim.log
rm -rf obj_dir "$log"

verilator --binary --timing --assert -f all.f --top-module exec_tb -o exec_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/exec_sim > "$log" 2>&1
status=$?
cat "$log"

if grep -q ">>> FAIL" "$log"; then
  echo "simulation reported a failure"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi
exit 0
